//--- src.f
source/sam_asic_pkg.sv
source/asic_port_decode.sv
source/asic_port_regs.sv
source/memory_pager.sv
source/midi_transmitter.sv
source/lpt_dac_mixer.sv
source/sam_asic_top.sv
verification/sam_asic_tb.sv

//--- verification/sam_asic_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sam_asic_tb;

	localparam int tick_div     = 4;
	localparam int frame_cycles = sam_asic_pkg::midi_frame_ticks * tick_div;
	// Interrupt covers the last 16 ticks of each frame
	localparam int int_cycles   = (sam_asic_pkg::midi_int_tick + 1) * tick_div;

	localparam logic [2:0] op_wr     = 3'd0;
	localparam logic [2:0] op_rd     = 3'd1;
	localparam logic [2:0] op_mem    = 3'd2;
	localparam logic [2:0] op_brd    = 3'd3;
	localparam logic [2:0] op_aud    = 3'd4;
	localparam logic [2:0] op_rise   = 3'd5;
	localparam logic [2:0] op_frames = 3'd6;

	typedef struct packed {
		logic [2:0]  op;
		logic        rnd;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [31:0] exp_val;
	} row_t;

	logic                   clk_sys;
	logic                   reset;
	sam_asic_pkg::cpu_bus_t bus;
	logic [7:0]             port_rdata;
	sam_asic_pkg::mem_map_t mem_map;
	logic [3:0]             border_color;
	logic                   midi_tx;
	logic                   int_midi;
	logic [15:0]            audio_l;
	logic [15:0]            audio_r;

	row_t        table_rows[$];
	logic [7:0]  shadow[256];
	logic [31:0] lfsr = 32'h5018c400;
	int          cycle = 0;
	int          cycle_limit = 0;
	int          rise_cycle = 0;
	logic        tx_seen = 1'b0;
	int          checks = 0;
	int          errors = 0;
	int          row_errors = 0;

	sam_asic_top #(
		.tick_div (tick_div)
	) uut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.port_rdata   (port_rdata),
		.mem_map      (mem_map),
		.border_color (border_color),
		.midi_tx      (midi_tx),
		.int_midi     (int_midi),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
	end

	// Cycle of the latest midi_tx rising edge
	always @(negedge clk_sys) begin
		if (midi_tx && !tx_seen) begin
			rise_cycle = cycle;
		end
		tx_seen = midi_tx;
	end

	always @(negedge clk_sys) begin
		if (cycle_limit != 0 && cycle >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles", cycle);
			$display("Done: errors found");
			$finish;
		end
	end

	// ======================================================================
	// Helpers
	// ======================================================================
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'hA3000000;
		end
		return s >> 1;
	endfunction

	task automatic random_byte(output logic [7:0] b);
		for (int n = 0; n < 8; n++) begin
			lfsr = lfsr_step(lfsr);
			b[n] = lfsr[0];
		end
	endtask

	// Page, ROM selects, protect and write enable in mem_map order
	function automatic logic [31:0] map_exp(input logic [8:0] page, input logic rom0,
			input logic rom1, input logic wp, input logic we);
		return {19'd0, page, rom0, rom1, wp, we};
	endfunction

	// Sample doubled, times four, beeper at 2^17, all over eight
	function automatic logic [15:0] mix_exp(input logic [7:0] d, input logic ear);
		int v;
		v = (int'({d, d}) * 4 + (ear ? 131072 : 0)) / 8;
		return v[15:0];
	endfunction

	function automatic string op_name(input logic [2:0] op);
		case (op)
			op_wr:   return "port write";
			op_rd:   return "port read";
			op_mem:  return "memory map";
			op_brd:  return "border";
			op_aud:  return "audio";
			op_rise: return "midi start";
			default: return "midi frames";
		endcase
	endfunction

	task automatic add_row(input logic [2:0] op, input logic rnd, input logic [15:0] addr,
			input logic [7:0] data, input logic [31:0] exp_val);
		row_t r;
		r.op      = op;
		r.rnd     = rnd;
		r.addr    = addr;
		r.data    = data;
		r.exp_val = exp_val;
		table_rows.push_back(r);
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("error at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
			errors++;
			row_errors++;
		end
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		bus.addr   = addr;
		bus.wdata  = data;
		bus.iorq_n = 1'b0;
		bus.wr_n   = 1'b0;
		repeat (2) @(negedge clk_sys);
		// Page bytes and border show up two cycles into the strobe
		if (addr[7:0] == sam_asic_pkg::port_lmpr
				|| addr[7:0] == sam_asic_pkg::port_hmpr) begin
			compare("port_rdata", port_rdata, data);
		end else if (addr[7:0] == sam_asic_pkg::port_brdr) begin
			compare("border_color", border_color, {data[5], data[2:0]});
		end
		@(negedge clk_sys);
		bus.iorq_n = 1'b1;
		bus.wr_n   = 1'b1;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic midi_rise();
		int waited;
		waited = 0;
		while (!midi_tx && waited < 4 * tick_div + 8) begin
			@(negedge clk_sys);
			waited++;
		end
		checks++;
		assert (midi_tx) else begin
			$display("midi_tx did not rise within %0d cycles of the MIDI write", waited);
			errors++;
			row_errors++;
		end
	endtask

	// Follows midi_tx until it falls, checking int_midi and the status port
	task automatic midi_frames(input int frames);
		int   k;
		int   limit_k;
		int   late_high;
		logic exp_int;
		bus.addr = {8'h00, sam_asic_pkg::port_stat};
		limit_k  = frames * frame_cycles + 2 * tick_div;
		@(negedge clk_sys);
		k = cycle - rise_cycle;
		while (midi_tx && k < limit_k) begin
			exp_int = (k % frame_cycles) >= (frame_cycles - int_cycles);
			compare("int_midi", int_midi, exp_int);
			compare("port_rdata", port_rdata, {3'b111, ~exp_int, 4'hF});
			@(negedge clk_sys);
			k = cycle - rise_cycle;
		end
		compare("midi_tx high cycles", k, frames * frame_cycles);
		late_high = 0;
		repeat (4 * tick_div) begin
			@(negedge clk_sys);
			if (midi_tx) begin
				late_high++;
			end
		end
		compare("midi_tx after frames", late_high, 0);
	endtask

	// ======================================================================
	// Stimulus table
	// ======================================================================
	task automatic build_table();
		// Read-back of random page bytes
		add_row(op_wr, 1'b1, 16'h00FA, 8'h00, 32'h0);
		add_row(op_wr, 1'b1, 16'h00FB, 8'h00, 32'h0);
		add_row(op_rd, 1'b1, 16'h00FA, 8'h00, 32'h0);
		add_row(op_rd, 1'b1, 16'h00FB, 8'h00, 32'h0);
		add_row(op_rd, 1'b0, 16'h1242, 8'h00, 32'hFF);
		add_row(op_rd, 1'b0, 16'h00F9, 8'h00, 32'hFF);
		// Pager without external RAM, page_ab 31 carries into bit 5
		add_row(op_wr, 1'b0, 16'h00FA, 8'h5F, 32'h0);
		add_row(op_wr, 1'b0, 16'h00FB, 8'h0A, 32'h0);
		add_row(op_wr, 1'b0, 16'h0080, 8'h12, 32'h0);
		add_row(op_wr, 1'b0, 16'h0081, 8'hC4, 32'h0);
		add_row(op_mem, 1'b0, 16'h0123, 8'h00, map_exp(9'd31, 1'b1, 1'b0, 1'b0, 1'b0));
		add_row(op_mem, 1'b0, 16'h4000, 8'h01, map_exp(9'd32, 1'b0, 1'b0, 1'b0, 1'b1));
		add_row(op_mem, 1'b0, 16'h8000, 8'h01, map_exp(9'd10, 1'b0, 1'b0, 1'b0, 1'b1));
		add_row(op_mem, 1'b0, 16'hC000, 8'h01, map_exp(9'd11, 1'b0, 1'b1, 1'b0, 1'b0));
		add_row(op_mem, 1'b0, 16'h0000, 8'h01, map_exp(9'd31, 1'b1, 1'b0, 1'b0, 1'b0));
		// Protected low quarter, ROMs off, external RAM on
		add_row(op_wr, 1'b0, 16'h00FA, 8'hA2, 32'h0);
		add_row(op_wr, 1'b0, 16'h00FB, 8'h8A, 32'h0);
		add_row(op_mem, 1'b0, 16'h1000, 8'h01, map_exp(9'd2, 1'b0, 1'b0, 1'b1, 1'b0));
		add_row(op_mem, 1'b0, 16'h5000, 8'h01, map_exp(9'd3, 1'b0, 1'b0, 1'b0, 1'b1));
		add_row(op_mem, 1'b0, 16'h9000, 8'h00, map_exp(9'h112, 1'b0, 1'b0, 1'b0, 1'b0));
		add_row(op_mem, 1'b0, 16'hD000, 8'h01, map_exp(9'h1C4, 1'b0, 1'b0, 1'b0, 1'b1));
		// Border colour and beeper
		add_row(op_wr, 1'b0, 16'h00FE, 8'h2D, 32'h0);
		add_row(op_brd, 1'b0, 16'h0000, 8'h00, 32'hD);
		add_row(op_aud, 1'b0, 16'h0000, 8'h00, {mix_exp(8'h00, 1'b0), mix_exp(8'h00, 1'b0)});
		add_row(op_wr, 1'b0, 16'h00FE, 8'h17, 32'h0);
		add_row(op_brd, 1'b0, 16'h0000, 8'h00, 32'h7);
		add_row(op_aud, 1'b0, 16'h0000, 8'h00, {mix_exp(8'h00, 1'b1), mix_exp(8'h00, 1'b1)});
		// DAC, rising strobe to the left, falling to the right
		add_row(op_wr, 1'b0, 16'h00E8, 8'hA5, 32'h0);
		add_row(op_wr, 1'b0, 16'h00E9, 8'h00, 32'h0);
		add_row(op_wr, 1'b0, 16'h00E9, 8'h01, 32'h0);
		add_row(op_aud, 1'b0, 16'h0000, 8'h00, {mix_exp(8'hA5, 1'b1), mix_exp(8'h00, 1'b1)});
		add_row(op_wr, 1'b0, 16'h00E8, 8'h3C, 32'h0);
		add_row(op_wr, 1'b0, 16'h00E9, 8'h01, 32'h0);
		add_row(op_wr, 1'b0, 16'h00E9, 8'h00, 32'h0);
		add_row(op_aud, 1'b0, 16'h0000, 8'h00, {mix_exp(8'hA5, 1'b1), mix_exp(8'h3C, 1'b1)});
		// One MIDI byte, then two more written during a frame
		add_row(op_wr, 1'b0, 16'h00FD, 8'h90, 32'h0);
		add_row(op_rise, 1'b0, 16'h0000, 8'h00, 32'h0);
		add_row(op_frames, 1'b0, 16'h0000, 8'd1, 32'h0);
		add_row(op_wr, 1'b0, 16'h00FD, 8'h80, 32'h0);
		add_row(op_rise, 1'b0, 16'h0000, 8'h00, 32'h0);
		add_row(op_wr, 1'b0, 16'h00FD, 8'h3C, 32'h0);
		add_row(op_wr, 1'b0, 16'h00FD, 8'h40, 32'h0);
		add_row(op_frames, 1'b0, 16'h0000, 8'd2, 32'h0);
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial begin
		row_t       r;
		logic [7:0] wdat;
		bus.addr   = 16'h0000;
		bus.wdata  = 8'h00;
		bus.mreq_n = 1'b1;
		bus.iorq_n = 1'b1;
		bus.rd_n   = 1'b1;
		bus.wr_n   = 1'b1;
		bus.m1_n   = 1'b1;
		reset      = 1'b1;
		build_table();
		cycle_limit = table_rows.size() * 8 + 3 * tick_div * 330;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;

		foreach (table_rows[i]) begin
			r = table_rows[i];
			row_errors = 0;
			case (r.op)
				op_wr: begin
					wdat = r.data;
					if (r.rnd) begin
						random_byte(wdat);
					end
					shadow[r.addr[7:0]] = wdat;
					io_write(r.addr, wdat);
				end
				op_rd: begin
					bus.addr   = r.addr;
					bus.iorq_n = 1'b0;
					bus.rd_n   = 1'b0;
					@(negedge clk_sys);
					compare("port_rdata", port_rdata,
						r.rnd ? shadow[r.addr[7:0]] : r.exp_val[7:0]);
					bus.iorq_n = 1'b1;
					bus.rd_n   = 1'b1;
				end
				op_mem: begin
					bus.addr   = r.addr;
					bus.wdata  = r.data;
					bus.mreq_n = 1'b0;
					bus.wr_n   = ~r.data[0];
					@(negedge clk_sys);
					compare("mem_map", {19'd0, mem_map}, r.exp_val);
					bus.mreq_n = 1'b1;
					bus.wr_n   = 1'b1;
				end
				op_brd: compare("border_color", border_color, r.exp_val[3:0]);
				op_aud: begin
					compare("audio_l", audio_l, r.exp_val[31:16]);
					compare("audio_r", audio_r, r.exp_val[15:0]);
				end
				op_rise: midi_rise();
				default: midi_frames(r.data);
			endcase
			$display("row %0d %s: %s", i, op_name(r.op), (row_errors == 0) ? "ok" : "failed");
		end

		$display("rows %0d, checks %0d, errors %0d", table_rows.size(), checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/sam_asic_top.sv
`timescale 1ns/1ps
`default_nettype none

module sam_asic_top #(
	parameter int tick_div = 96
) (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  sam_asic_pkg::cpu_bus_t  bus,
	output logic [7:0]              port_rdata,
	output sam_asic_pkg::mem_map_t  mem_map,
	output logic [3:0]              border_color,
	output logic                    midi_tx,
	output logic                    int_midi,
	output logic [15:0]             audio_l,
	output logic [15:0]             audio_r
);

	sam_asic_pkg::port_write_t port_write;
	sam_asic_pkg::page_regs_t  page_regs;
	sam_asic_pkg::brdr_t       border;

	asic_port_decode u_decode (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus),
		.port_write (port_write)
	);

	asic_port_regs u_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.port_write (port_write),
		.addr       (bus.addr),
		.int_midi   (int_midi),
		.page_regs  (page_regs),
		.border     (border),
		.port_rdata (port_rdata)
	);

	memory_pager u_pager (
		.bus       (bus),
		.page_regs (page_regs),
		.mem_map   (mem_map)
	);

	midi_transmitter #(
		.tick_div (tick_div)
	) u_midi (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.port_write (port_write),
		.midi_tx    (midi_tx),
		.int_midi   (int_midi)
	);

	lpt_dac_mixer u_dac (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.port_write (port_write),
		.ear        (border.ear),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

	// Colour bit 3 sits above the beeper bits in the border register
	assign border_color = {border.color_hi, border.color_lo};

endmodule

`default_nettype wire

//--- source/lpt_dac_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module lpt_dac_mixer (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  sam_asic_pkg::port_write_t port_write,
	input  wire                       ear,
	output logic [15:0]               audio_l,
	output logic [15:0]               audio_r
);

	logic [7:0]  data;
	logic        old_stb;
	logic [7:0]  vox_l;
	logic [7:0]  vox_r;
	logic [18:0] mix_l;
	logic [18:0] mix_r;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			data    <= '0;
			old_stb <= 1'b0;
			vox_l   <= '0;
			vox_r   <= '0;
		end else if (port_write.valid) begin
			if (port_write.sel.lptd) begin
				data <= port_write.data;
			end
			if (port_write.sel.lpts) begin
				// Strobe edge picks the channel
				if (!old_stb && port_write.data[0]) begin
					vox_l <= data;
				end
				if (old_stb && !port_write.data[0]) begin
					vox_r <= data;
				end
				old_stb <= port_write.data[0];
			end
		end
	end

	// Sample doubled to 16 bits, beeper on bit 17, then scaled down by 8
	assign mix_l = {1'b0, vox_l, vox_l, 2'b00} + {1'b0, ear, 17'd0};
	assign mix_r = {1'b0, vox_r, vox_r, 2'b00} + {1'b0, ear, 17'd0};

	assign audio_l = mix_l[18:3];
	assign audio_r = mix_r[18:3];

endmodule

`default_nettype wire

//--- source/midi_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module midi_transmitter #(
	parameter int tick_div = 96
) (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  sam_asic_pkg::port_write_t port_write,
	output logic                      midi_tx,
	output logic                      int_midi
);

	localparam int div_w = $clog2(tick_div);

	logic [div_w-1:0] div_cnt;
	logic             tick;
	logic [8:0]       tx_time;
	logic             pending;

	// ======================================================================
	// 1 MHz tick
	// ======================================================================
	assign tick = (div_cnt == div_w'(tick_div - 1));

	always_ff @(posedge clk_sys) begin
		if (reset || tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// ======================================================================
	// Frame timer
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tx_time  <= '0;
			midi_tx  <= 1'b0;
			int_midi <= 1'b0;
			pending  <= 1'b0;
		end else begin
			if (tick) begin
				if (tx_time != '0) begin
					tx_time <= tx_time - 1'b1;
					// Rises as the timer steps down to the interrupt value
					if (tx_time == 9'(sam_asic_pkg::midi_int_tick + 1)) begin
						int_midi <= 1'b1;
					end
				end else begin
					midi_tx  <= 1'b0;
					int_midi <= 1'b0;
					if (pending) begin
						midi_tx <= 1'b1;
						tx_time <= 9'(sam_asic_pkg::midi_frame_ticks - 1);
						pending <= 1'b0;
					end
				end
			end
			// New byte wins over the one just started
			if (port_write.valid && port_write.sel.midi) begin
				pending <= 1'b1;
			end
		end
	end

	a_int_in_frame: assert property (@(posedge clk_sys) disable iff (reset)
		int_midi |-> midi_tx)
		else $error("MIDI interrupt outside a transmit frame");

endmodule

`default_nettype wire

//--- source/memory_pager.sv
`timescale 1ns/1ps
`default_nettype none

module memory_pager (
	input  sam_asic_pkg::cpu_bus_t   bus,
	input  sam_asic_pkg::page_regs_t page_regs,
	output sam_asic_pkg::mem_map_t   mem_map
);

	logic [1:0] quarter;
	logic       ext_ram;
	logic       mem_wr;

	assign quarter = bus.addr[15:14];
	assign mem_wr  = ~bus.mreq_n & ~bus.wr_n;

	// External RAM covers the whole upper half
	assign ext_ram = page_regs.hmpr.ext_ram & bus.addr[15];

	assign mem_map.rom0_sel = ~page_regs.lmpr.rom0_off & (quarter == 2'd0);
	assign mem_map.rom1_sel = page_regs.lmpr.rom1_en & (quarter == 2'd3);
	assign mem_map.ram_wp   = page_regs.lmpr.wp & (quarter == 2'd0);

	always_comb begin
		if (ext_ram) begin
			if (bus.addr[14]) begin
				mem_map.ram_page = {1'b1, page_regs.ext_d};
			end else begin
				mem_map.ram_page = {1'b1, page_regs.ext_c};
			end
		end else begin
			// Odd quarters take the next page, carry kept in the wider result
			case (quarter)
				2'd0:    mem_map.ram_page = 9'(page_regs.lmpr.page_ab);
				2'd1:    mem_map.ram_page = 9'(page_regs.lmpr.page_ab) + 9'd1;
				2'd2:    mem_map.ram_page = 9'(page_regs.hmpr.page_cd);
				default: mem_map.ram_page = 9'(page_regs.hmpr.page_cd) + 9'd1;
			endcase
		end
	end

	assign mem_map.ram_we = mem_wr
		& ~(mem_map.rom0_sel | mem_map.rom1_sel | mem_map.ram_wp);

endmodule

`default_nettype wire

//--- source/asic_port_regs.sv
`timescale 1ns/1ps
`default_nettype none

module asic_port_regs (
	input  wire                       clk_sys,
	input  wire                       reset,
	input  sam_asic_pkg::port_write_t port_write,
	input  wire  [15:0]               addr,
	input  wire                       int_midi,
	output sam_asic_pkg::page_regs_t  page_regs,
	output sam_asic_pkg::brdr_t       border,
	output logic [7:0]                port_rdata
);

	// ======================================================================
	// Write side
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_regs <= '0;
			border    <= '0;
		end else if (port_write.valid) begin
			if (port_write.sel.lmpr) begin
				page_regs.lmpr <= port_write.data;
			end
			if (port_write.sel.hmpr) begin
				page_regs.hmpr <= port_write.data;
			end
			if (port_write.sel.ext_c) begin
				page_regs.ext_c <= port_write.data;
			end
			if (port_write.sel.ext_d) begin
				page_regs.ext_d <= port_write.data;
			end
			if (port_write.sel.brdr) begin
				border <= port_write.data;
			end
		end
	end

	// ======================================================================
	// Read-back, straight from the address
	// ======================================================================
	always_comb begin
		case (addr[7:0])
			sam_asic_pkg::port_lmpr: port_rdata = page_regs.lmpr;
			sam_asic_pkg::port_hmpr: port_rdata = page_regs.hmpr;
			// Status: MIDI interrupt is active low on bit 4
			sam_asic_pkg::port_stat: port_rdata = {3'b111, ~int_midi, 4'b1111};
			default:                 port_rdata = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

//--- source/asic_port_decode.sv
`timescale 1ns/1ps
`default_nettype none

module asic_port_decode (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  sam_asic_pkg::cpu_bus_t bus,
	output sam_asic_pkg::port_write_t port_write
);

	logic                   port_we;
	logic                   old_we;
	sam_asic_pkg::port_sel_t sel_next;

	// I/O write outside of an interrupt acknowledge
	assign port_we = ~bus.iorq_n & ~bus.wr_n & bus.m1_n;

	// One compare per port against the low address byte
	always_comb begin
		sel_next.lmpr  = (bus.addr[7:0] == sam_asic_pkg::port_lmpr);
		sel_next.hmpr  = (bus.addr[7:0] == sam_asic_pkg::port_hmpr);
		sel_next.brdr  = (bus.addr[7:0] == sam_asic_pkg::port_brdr);
		sel_next.stat  = (bus.addr[7:0] == sam_asic_pkg::port_stat);
		sel_next.midi  = (bus.addr[7:0] == sam_asic_pkg::port_midi);
		sel_next.lptd  = (bus.addr[7:0] == sam_asic_pkg::port_lptd);
		sel_next.lpts  = (bus.addr[7:0] == sam_asic_pkg::port_lpts);
		sel_next.ext_c = (bus.addr[7:0] == sam_asic_pkg::port_ext_c);
		sel_next.ext_d = (bus.addr[7:0] == sam_asic_pkg::port_ext_d);
	end

	// Strobe history and the one-cycle event flag
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_we           <= 1'b0;
			port_write.valid <= 1'b0;
		end else begin
			old_we           <= port_we;
			port_write.valid <= port_we & ~old_we;
		end
	end

	// Payload follows the bus, only meaningful with valid
	always_ff @(posedge clk_sys) begin
		port_write.sel  <= sel_next;
		port_write.data <= bus.wdata;
	end

	a_sel_onehot: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0(port_write.sel))
		else $error("port decoder selected more than one port");

endmodule

`default_nettype wire

//--- source/sam_asic_pkg.sv
`default_nettype none

package sam_asic_pkg;

	// ======================================================================
	// Port addresses, low byte of the I/O address
	// ======================================================================
	localparam logic [7:0] port_lmpr  = 8'hFA;
	localparam logic [7:0] port_hmpr  = 8'hFB;
	localparam logic [7:0] port_brdr  = 8'hFE;
	localparam logic [7:0] port_stat  = 8'hF9;
	localparam logic [7:0] port_midi  = 8'hFD;
	localparam logic [7:0] port_lptd  = 8'hE8;
	localparam logic [7:0] port_lpts  = 8'hE9;
	localparam logic [7:0] port_ext_c = 8'h80;
	localparam logic [7:0] port_ext_d = 8'h81;

	// MIDI byte length in 1 MHz ticks, and the point where the interrupt rises
	localparam int midi_frame_ticks = 320;
	localparam int midi_int_tick    = 15;

	// ======================================================================
	// Shared structs
	// ======================================================================
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        mreq_n;
		logic        iorq_n;
		logic        rd_n;
		logic        wr_n;
		logic        m1_n;
	} cpu_bus_t;

	typedef struct packed {
		logic lmpr;
		logic hmpr;
		logic brdr;
		logic stat;
		logic midi;
		logic lptd;
		logic lpts;
		logic ext_c;
		logic ext_d;
	} port_sel_t;

	typedef struct packed {
		logic       valid;
		port_sel_t  sel;
		logic [7:0] data;
	} port_write_t;

	typedef struct packed {
		logic       wp;
		logic       rom1_en;
		logic       rom0_off;
		logic [4:0] page_ab;
	} lmpr_t;

	typedef struct packed {
		logic       ext_ram;
		logic [1:0] mode3_hi;
		logic [4:0] page_cd;
	} hmpr_t;

	typedef struct packed {
		logic       soff;
		logic       unused;
		logic       color_hi;
		logic       ear;
		logic       mic;
		logic [2:0] color_lo;
	} brdr_t;

	typedef struct packed {
		lmpr_t      lmpr;
		hmpr_t      hmpr;
		logic [7:0] ext_c;
		logic [7:0] ext_d;
	} page_regs_t;

	typedef struct packed {
		logic [8:0] ram_page;
		logic       rom0_sel;
		logic       rom1_sel;
		logic       ram_wp;
		logic       ram_we;
	} mem_map_t;

endpackage

`default_nettype wire
